// ==== bench/perm_checker.sv ====
// permutation checker: reference keccak model, stream monitor and mismatch counting
module perm_checker import keccak_pkg::*, lane_io_pkg::*; #(
	parameter int NUM_ROUNDS = 24
) (
	input logic clk,
	input logic rst,
	input logic pushin,
	input logic stopin,
	input stream_beat_t in_beat,
	input logic pushout,
	input logic stopout,
	input stream_beat_t out_beat,
	output int err_cnt,
	output int blocks_in,
	output int blocks_out,
	output int stray_cnt
);

	// model phase: 0 idle, 1 load, 2 rounds, 3 unload
	int mphase;
	int lane_pos;
	int rnd_cnt;
	int rot_off [LANES];
	// model state in x + 5y order, bt is scratch
	lane_t st [LANES];
	lane_t bt [LANES];

	// bit i of the input lands on bit (i + n) mod 64
	function automatic lane_t rot_left(lane_t v, int n);
		lane_t r;
		for (int i = 0; i < 64; i++) begin
			r[(i + n) % 64] = v[i];
		end
		return r;
	endfunction

	// spec LFSR output t steps after seed 1
	function automatic logic lfsr_bit(int t);
		logic [8:0] r;
		r = 9'h001;
		for (int i = 0; i < t % 255; i++) begin
			r = r << 1;
			// bit 8 folds back onto taps 0, 4, 5, 6
			if (r[8]) begin
				r = r ^ 9'h171;
			end
		end
		return r[0];
	endfunction

	// triangular numbers along the walk (x,y) -> (y, 2x+3y)
	task automatic build_offsets();
		int x;
		int y;
		int nx;
		rot_off[0] = 0;
		x = 1;
		y = 0;
		for (int t = 0; t < 24; t++) begin
			rot_off[x + 5 * y] = ((t + 1) * (t + 2) / 2) % 64;
			nx = y;
			y = (2 * x + 3 * y) % 5;
			x = nx;
		end
	endtask

	task automatic permute();
		lane_t c [5];
		lane_t d;
		for (int r = 0; r < NUM_ROUNDS; r++) begin
			for (int x = 0; x < 5; x++) begin
				c[x] = st[x] ^ st[x + 5] ^ st[x + 10] ^ st[x + 15] ^ st[x + 20];
			end
			// theta, column of lane i is i mod 5
			for (int i = 0; i < LANES; i++) begin
				d = c[(i + 4) % 5] ^ rot_left(c[(i + 1) % 5], 1);
				bt[i] = st[i] ^ d;
			end
			// rho then pi, lane (x,y) lands on (y, 2x+3y)
			for (int i = 0; i < LANES; i++) begin
				st[i / 5 + 5 * ((2 * (i % 5) + 3 * (i / 5)) % 5)] = rot_left(bt[i], rot_off[i]);
			end
			// chi within each plane
			for (int i = 0; i < LANES; i++) begin
				bt[i] = st[i] ^ (~st[(i + 1) % 5 + 5 * (i / 5)] & st[(i + 2) % 5 + 5 * (i / 5)]);
			end
			st = bt;
			// iota bits sit at 2^j - 1
			for (int j = 0; j < 7; j++) begin
				st[0][(1 << j) - 1] = st[0][(1 << j) - 1] ^ lfsr_bit(j + 7 * r);
			end
		end
	endtask

	task automatic mismatch(string name, lane_t expv, lane_t gotv);
		$display("CHECK FAILED t=%0t %s expected %0h got %0h", $time, name, expv, gotv);
		err_cnt++;
	endtask

	initial begin
		err_cnt = 0;
		blocks_in = 0;
		blocks_out = 0;
		stray_cnt = 0;
		build_offsets();
		// all-zero input has a published first lane
		for (int i = 0; i < LANES; i++) begin
			st[i] = '0;
		end
		permute();
		if (NUM_ROUNDS == 24 && st[0] !== 64'hf1258f7940e1dde7) begin
			mismatch("model lane 0", 64'hf1258f7940e1dde7, st[0]);
		end
	end

	always @(posedge clk or posedge rst) begin
		if (rst) begin
			mphase = 0;
			lane_pos = 0;
			rnd_cnt = 0;
		end else begin
			// input closed from rounds to the last output lane
			if (stopin !== (mphase >= 2)) begin
				mismatch("stopin", lane_t'(mphase >= 2), lane_t'(stopin));
			end
			if (pushout !== (mphase == 3)) begin
				mismatch("pushout", lane_t'(mphase == 3), lane_t'(pushout));
			end
			// the first marker only belongs to lane 0 of an unloading block
			if (mphase != 3 && out_beat.first !== 1'b0) begin
				mismatch("out_beat.first", lane_t'(0), lane_t'(out_beat.first));
			end
			case (mphase)
				0: begin
					if (pushin && in_beat.first) begin
						st[0] = in_beat.data;
						lane_pos = 1;
						mphase = 1;
					end else if (pushin) begin
						stray_cnt++;
					end
				end
				1: begin
					if (pushin) begin
						st[lane_pos] = in_beat.data;
						lane_pos++;
						if (lane_pos == LANES) begin
							permute();
							blocks_in++;
							rnd_cnt = 0;
							mphase = 2;
						end
					end
				end
				2: begin
					// one edge per round, then the output opens
					rnd_cnt++;
					if (rnd_cnt == NUM_ROUNDS) begin
						lane_pos = 0;
						mphase = 3;
					end
				end
				default: begin
					if (out_beat.first !== (lane_pos == 0)) begin
						mismatch("out_beat.first", lane_t'(lane_pos == 0), lane_t'(out_beat.first));
					end
					// a stalled beat is held and checked again
					if (out_beat.data !== st[lane_pos]) begin
						mismatch($sformatf("out_beat.data lane %0d", lane_pos),
							st[lane_pos], out_beat.data);
					end
					if (!stopout) begin
						lane_pos++;
						if (lane_pos == LANES) begin
							blocks_out++;
							mphase = 0;
						end
					end
				end
			endcase
		end
	end

endmodule

// ==== bench/tb_keccak_perm.sv ====
// testbench top: clock, reset, seeded random lane blocks, output stalls and watchdog
module tb_keccak_perm import keccak_pkg::*, lane_io_pkg::*; ();

	localparam int NUM_ROUNDS = 24;
	localparam int CLK_PERIOD = 4;
	localparam logic [31:0] SEED = 32'ha22ceaae;
	// blocks per test, in run order
	localparam int ZERO_BLOCKS = 1;
	localparam int PLAIN_BLOCKS = 8;
	localparam int STALL_BLOCKS = 8;
	localparam int STRAY_BLOCKS = 4;
	localparam int BURST_BLOCKS = 3;
	localparam int TOTAL_BLOCKS = ZERO_BLOCKS + PLAIN_BLOCKS + STALL_BLOCKS
		+ STRAY_BLOCKS + BURST_BLOCKS;
	// longest input gap and longest stopout run, in cycles
	localparam int MAX_GAP = 3;
	localparam int MAX_STALL = 3;
	localparam int STALL_PCT = 40;
	localparam int WATCHDOG_LIMIT = TOTAL_BLOCKS
		* (25 * MAX_GAP + NUM_ROUNDS + 25 * MAX_STALL + 10) * CLK_PERIOD * 2;

	logic clk;
	logic rst;
	logic pushin;
	logic stopin;
	logic pushout;
	logic stopout;
	stream_beat_t in_beat;
	stream_beat_t out_beat;
	int stall_pct;
	int stall_left;
	int sent_blocks;
	int err_cnt;
	int blocks_in;
	int blocks_out;
	int stray_cnt;
	int err_mark;
	int stray_mark;
	int test_num;
	lane_t blk [LANES];

	task automatic wait_idle();
		while (stopin) begin
			@(negedge clk);
		end
	endtask

	task automatic send_stray(int n);
		wait_idle();
		for (int i = 0; i < n; i++) begin
			pushin = 1;
			in_beat = '{first: 1'b0, data: {$urandom, $urandom}};
			@(negedge clk);
		end
		pushin = 0;
	endtask

	task automatic send_block(int max_gap);
		int gap;
		for (int i = 0; i < LANES; i++) begin
			gap = $urandom % (max_gap + 1);
			if (gap > 0) begin
				pushin = 0;
				repeat (gap) @(negedge clk);
			end
			// lane 0 waits for the previous block to drain
			wait_idle();
			pushin = 1;
			in_beat = '{first: (i == 0), data: blk[i]};
			@(negedge clk);
		end
		pushin = 0;
		in_beat = '0;
		sent_blocks++;
	endtask

	task automatic run_blocks(int n, bit zero, int max_gap, int max_stray);
		for (int b = 0; b < n; b++) begin
			if (max_stray > 0) begin
				send_stray(1 + $urandom % max_stray);
			end
			for (int i = 0; i < LANES; i++) begin
				blk[i] = zero ? lane_t'(0) : {$urandom, $urandom};
			end
			send_block(max_gap);
		end
		// every block out before the test closes
		while (blocks_out < sent_blocks) begin
			@(negedge clk);
		end
	endtask

	task automatic close_test(string name, int n);
		test_num++;
		$display("test %0d %s: %0d blocks, %0d stray beats, %0d errors", test_num, name, n,
			stray_cnt - stray_mark, err_cnt - err_mark);
		err_mark = err_cnt;
		stray_mark = stray_cnt;
	endtask

	initial begin
		clk = 0;
		forever #(CLK_PERIOD / 2) clk = ~clk;
	end

	// stopout runs last 1 to MAX_STALL cycles with a low cycle after each
	initial begin
		stopout = 0;
		stall_left = 0;
		forever begin
			@(negedge clk);
			if (stall_left > 0) begin
				stopout = 1;
				stall_left--;
			end else if (stopout) begin
				stopout = 0;
			end else if (stall_pct > 0 && ($urandom % 100) < stall_pct) begin
				stall_left = $urandom % MAX_STALL;
				stopout = 1;
			end else begin
				stopout = 0;
			end
		end
	end

	initial begin
		int unsigned seed;
		int unsigned first_draw;
		seed = SEED;
		first_draw = $urandom(seed);
		rst = 1;
		pushin = 0;
		in_beat = '0;
		stall_pct = 0;
		sent_blocks = 0;
		err_mark = 0;
		stray_mark = 0;
		test_num = 0;
		repeat (4) @(negedge clk);
		rst = 0;
		run_blocks(ZERO_BLOCKS, 1, 0, 0);
		close_test("zero block", ZERO_BLOCKS);
		run_blocks(PLAIN_BLOCKS, 0, MAX_GAP, 0);
		close_test("random blocks with input gaps", PLAIN_BLOCKS);
		stall_pct = STALL_PCT;
		run_blocks(STALL_BLOCKS, 0, MAX_GAP, 0);
		stall_pct = 0;
		close_test("random output back-pressure", STALL_BLOCKS);
		run_blocks(STRAY_BLOCKS, 0, 1, 3);
		close_test("stray beats while idle", STRAY_BLOCKS);
		run_blocks(BURST_BLOCKS, 0, 0, 0);
		close_test("back-to-back blocks, fixed latency", BURST_BLOCKS);
		$display("summary: %0d tests, %0d blocks sent, %0d accepted, %0d checked, %0d errors",
			test_num, sent_blocks, blocks_in, blocks_out, err_cnt);
		if (err_cnt == 0) begin
			$display("TEST OK");
		end else begin
			$display("TEST FAILED");
		end
		$finish;
	end

	initial begin
		#(WATCHDOG_LIMIT);
		$display("watchdog: the run did not finish within %0d time units", WATCHDOG_LIMIT);
		$display("TEST FAILED");
		$finish;
	end

	keccak_perm_blk #(
		.NUM_ROUNDS(NUM_ROUNDS)
	) u_dut (
		.clk(clk),
		.rst(rst),
		.pushin(pushin),
		.stopin(stopin),
		.in_beat(in_beat),
		.pushout(pushout),
		.stopout(stopout),
		.out_beat(out_beat)
	);

	perm_checker #(
		.NUM_ROUNDS(NUM_ROUNDS)
	) u_chk (
		.clk(clk),
		.rst(rst),
		.pushin(pushin),
		.stopin(stopin),
		.in_beat(in_beat),
		.pushout(pushout),
		.stopout(stopout),
		.out_beat(out_beat),
		.err_cnt(err_cnt),
		.blocks_in(blocks_in),
		.blocks_out(blocks_out),
		.stray_cnt(stray_cnt)
	);

endmodule

// ==== hdl/chi_iota_step.sv ====
// chi and iota steps: nonlinear row mix and round constant into lane (0,0)
module chi_iota_step import keccak_pkg::*; (
	input keccak_state_u state_in,
	input lane_t rc,
	output keccak_state_u state_out
);

	always_comb begin
		// each plane is mixed on its own
		for (int y = 0; y < GRID; y++) begin
			for (int x = 0; x < GRID; x++) begin
				state_out.planes[y][x] = state_in.planes[y][x]
					^ (~state_in.planes[y][(x + 1) % GRID]
					& state_in.planes[y][(x + 2) % GRID]);
			end
		end
		// iota only touches lane (0,0)
		state_out.planes[0][0] = state_out.planes[0][0] ^ rc;
	end

endmodule

// ==== hdl/keccak_perm_blk.sv ====
// keccak-f[1600] permutation block: controller beside the lane store and round datapath
module keccak_perm_blk import keccak_pkg::*, lane_io_pkg::*; #(
	parameter int NUM_ROUNDS = 24
) (
	input logic clk,
	input logic rst,
	input logic pushin,
	output logic stopin,
	input stream_beat_t in_beat,
	output logic pushout,
	input logic stopout,
	output stream_beat_t out_beat
);

	store_cmd_t cmd;
	logic rc_restart;
	logic out_first;
	lane_t rc;

	// stored state and the three combinational stages of one round
	keccak_state_u state;
	keccak_state_u theta_out;
	keccak_state_u rho_pi_out;
	keccak_state_u round_result;

	// output lane is always slot 0 of the store
	assign out_beat = '{first: out_first, data: state.lanes[0]};

	perm_ctrl #(
		.NUM_ROUNDS(NUM_ROUNDS)
	) u_ctrl (
		.clk(clk),
		.rst(rst),
		.pushin(pushin),
		.in_first(in_beat.first),
		.stopin(stopin),
		.pushout(pushout),
		.stopout(stopout),
		.out_first(out_first),
		.cmd(cmd),
		.rc_restart(rc_restart)
	);

	// constants advance with every round step
	round_const_gen u_rc (
		.clk(clk),
		.rst(rst),
		.restart(rc_restart),
		.step(cmd.step),
		.rc(rc)
	);

	lane_store u_store (
		.clk(clk),
		.rst(rst),
		.cmd(cmd),
		.load_lane(in_beat.data),
		.round_result(round_result),
		.state(state)
	);

	theta_step u_theta (
		.state_in(state),
		.state_out(theta_out)
	);

	rho_pi_step u_rho_pi (
		.state_in(theta_out),
		.state_out(rho_pi_out)
	);

	chi_iota_step u_chi_iota (
		.state_in(rho_pi_out),
		.rc(rc),
		.state_out(round_result)
	);

endmodule

// ==== hdl/keccak_pkg.sv ====
// keccak arithmetic package: lane and state types, rotation table, rotate helper
package keccak_pkg;

	// one 64-bit lane of the keccak state
	typedef logic [63:0] lane_t;

	// lanes in the full 1600-bit state
	localparam int LANES = 25;

	// plane grid is 5 by 5
	localparam int GRID = 5;

	// lane position in streaming order, x fastest
	typedef logic [4:0] lane_idx_t;

	// round number inside one permutation
	typedef logic [4:0] round_idx_t;

	// two views of the same 1600 bits
	// lanes view is indexed x + 5y for streaming
	// planes view is indexed [y][x] for the round steps
	typedef union packed {
		lane_t [LANES-1:0] lanes;
		lane_t [GRID-1:0][GRID-1:0] planes;
	} keccak_state_u;

	// rho rotation amounts, indexed x + 5y
	localparam int RHO_OFFSET [LANES] = '{
		0, 1, 62, 28, 27,
		36, 44, 6, 55, 20,
		3, 10, 43, 25, 39,
		41, 45, 15, 21, 8,
		18, 2, 61, 56, 14
	};

	// rotate a lane left by n bit positions
	function automatic lane_t rotl(lane_t v, int unsigned n);
		// a zero amount leaves the lane as it is
		if (n == 0) begin
			return v;
		end
		return (v << n) | (v >> (64 - n));
	endfunction

endpackage

// ==== hdl/lane_io_pkg.sv ====
// lane stream package: stream beat format and lane store command word
package lane_io_pkg;

	// one beat on the input or output lane stream
	// first marks lane (0,0) of a block
	typedef struct packed {
		logic first;
		keccak_pkg::lane_t data;
	} stream_beat_t;

	// controller to lane store commands
	// at most one bit is set in any cycle
	typedef struct packed {
		// shift a new lane in at the top
		logic load;
		// replace the state with the round result
		logic step;
		// shift the state down one lane for output
		logic advance;
	} store_cmd_t;

endpackage

// ==== hdl/lane_store.sv ====
// lane store: 25-lane keccak state register with shift-in, round update and shift-out
module lane_store import keccak_pkg::*, lane_io_pkg::*; (
	input logic clk,
	input logic rst,
	input store_cmd_t cmd,
	input lane_t load_lane,
	input keccak_state_u round_result,
	output keccak_state_u state
);

	// lanes move down one slot per load or advance
	// new lanes enter at the top slot
	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			state <= '0;
		end else if (cmd.load) begin
			// after 25 loads the oldest lane sits at slot 0
			state.lanes <= {load_lane, state.lanes[LANES-1:1]};
		end else if (cmd.step) begin
			// whole state replaced by one round
			state <= round_result;
		end else if (cmd.advance) begin
			// next output lane drops into slot 0
			state.lanes <= {lane_t'('0), state.lanes[LANES-1:1]};
		end
	end

endmodule

// ==== hdl/perm_ctrl.sv ====
// permutation controller: phase FSM, lane and round counters, stream and store control
module perm_ctrl import keccak_pkg::*, lane_io_pkg::*; #(
	parameter int NUM_ROUNDS = 24
) (
	input logic clk,
	input logic rst,
	input logic pushin,
	input logic in_first,
	output logic stopin,
	output logic pushout,
	input logic stopout,
	output logic out_first,
	output store_cmd_t cmd,
	output logic rc_restart
);

	typedef enum logic [1:0] {
		IDLE,
		LOAD,
		ROUND,
		UNLOAD
	} phase_t;

	phase_t phase;
	// lanes taken in during LOAD, lanes sent out during UNLOAD
	lane_idx_t lane_cnt;
	round_idx_t round_cnt;

	logic in_xfer;
	logic out_xfer;
	logic last_lane;
	logic last_round;
	logic load_done;
	logic unload_done;

	// input is only closed while the state is busy or draining
	assign stopin = (phase == ROUND) || (phase == UNLOAD);
	assign in_xfer = pushin && !stopin;

	assign pushout = (phase == UNLOAD);
	assign out_xfer = pushout && !stopout;
	// lane 0 is at the bottom of the store until the first advance
	assign out_first = pushout && (lane_cnt == '0);

	assign last_lane = (lane_cnt == lane_idx_t'(LANES - 1));
	assign last_round = (round_cnt == round_idx_t'(NUM_ROUNDS - 1));

	// idle beats without first are accepted and dropped
	// inside LOAD the first bit is not looked at
	assign cmd = '{
		load: in_xfer && ((phase == LOAD) || in_first),
		step: (phase == ROUND),
		advance: out_xfer
	};

	// constants start over with every new block
	assign rc_restart = (phase == IDLE) && cmd.load;

	assign load_done = (phase == LOAD) && cmd.load && last_lane;
	assign unload_done = out_xfer && last_lane;

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			phase <= IDLE;
			lane_cnt <= '0;
			round_cnt <= '0;
		end else begin
			case (phase)
				IDLE: begin
					// the first lane is already in the store
					if (cmd.load) begin
						lane_cnt <= lane_idx_t'(1);
						phase <= LOAD;
					end
				end
				LOAD: begin
					if (cmd.load) begin
						if (last_lane) begin
							lane_cnt <= '0;
							round_cnt <= '0;
							phase <= ROUND;
						end else begin
							lane_cnt <= lane_cnt + 5'd1;
						end
					end
				end
				ROUND: begin
					// one round per clock, no waiting
					if (last_round) begin
						phase <= UNLOAD;
					end else begin
						round_cnt <= round_cnt + 5'd1;
					end
				end
				UNLOAD: begin
					// stopout freezes the count and the store together
					if (out_xfer) begin
						if (last_lane) begin
							lane_cnt <= '0;
							phase <= IDLE;
						end else begin
							lane_cnt <= lane_cnt + 5'd1;
						end
					end
				end
				default: begin
					phase <= IDLE;
				end
			endcase
		end
	end

	// input stays closed from the last load until the last lane leaves
	a_stopin_busy: assert property (@(posedge clk) disable iff (rst)
		load_done |=> (stopin until_with unload_done));

	// load, step and advance never collide
	a_cmd_onehot: assert property (@(posedge clk) disable iff (rst)
		$onehot0(cmd));

	// output opens only right after the final round
	a_pushout_rise: assert property (@(posedge clk) disable iff (rst)
		$rose(pushout) |-> $past((phase == ROUND) && last_round));

endmodule

// ==== hdl/rho_pi_step.sv ====
// rho and pi steps: per-lane rotation followed by lane relocation
module rho_pi_step import keccak_pkg::*; (
	input keccak_state_u state_in,
	output keccak_state_u state_out
);

	// lane (x,y) rotates by its table entry
	// then it moves to (y, 2x+3y mod 5)
	always_comb begin
		for (int y = 0; y < GRID; y++) begin
			for (int x = 0; x < GRID; x++) begin
				// destination plane index is the new y
				state_out.planes[(2 * x + 3 * y) % GRID][y] =
					rotl(state_in.planes[y][x], RHO_OFFSET[x + GRID * y]);
			end
		end
	end

endmodule

// ==== hdl/round_const_gen.sv ====
// round constant generator: 8-bit LFSR unrolled into the 64-bit iota constant
module round_const_gen import keccak_pkg::*; (
	input logic clk,
	input logic rst,
	input logic restart,
	input logic step,
	output lane_t rc
);

	// spec LFSR, x^8+x^6+x^5+x^4+1, bit 0 is the output
	logic [7:0] lfsr;
	logic [7:0] walk;
	logic [7:0] lfsr_next;

	// seven outputs land on bit positions 2^j - 1
	always_comb begin
		walk = lfsr;
		rc = '0;
		for (int j = 0; j < 7; j++) begin
			rc[(1 << j) - 1] = walk[0];
			// feedback taps fold back when bit 7 shifts out
			walk = {walk[6:0], 1'b0} ^ (walk[7] ? 8'h71 : 8'h00);
		end
		lfsr_next = walk;
	end

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			lfsr <= 8'h01;
		end else if (restart) begin
			// new block starts again at round 0
			lfsr <= 8'h01;
		end else if (step) begin
			lfsr <= lfsr_next;
		end
	end

	// zero would lock the LFSR and kill every later constant
	a_lfsr_live: assert property (@(posedge clk) disable iff (rst)
		lfsr != 8'h00);

endmodule

// ==== hdl/theta_step.sv ====
// theta step: column parities mixed back into every lane of the state
module theta_step import keccak_pkg::*; (
	input keccak_state_u state_in,
	output keccak_state_u state_out
);

	// parity of each column x over all five planes
	lane_t [GRID-1:0] parity;

	always_comb begin
		for (int x = 0; x < GRID; x++) begin
			parity[x] = '0;
			for (int y = 0; y < GRID; y++) begin
				parity[x] = parity[x] ^ state_in.planes[y][x];
			end
		end
	end

	// left neighbour column plain, right neighbour rotated by one
	always_comb begin
		for (int y = 0; y < GRID; y++) begin
			for (int x = 0; x < GRID; x++) begin
				state_out.planes[y][x] = state_in.planes[y][x]
					^ parity[(x + GRID - 1) % GRID]
					^ rotl(parity[(x + 1) % GRID], 1);
			end
		end
	end

endmodule

// ==== sources.f ====
hdl/keccak_pkg.sv
hdl/lane_io_pkg.sv
hdl/theta_step.sv
hdl/rho_pi_step.sv
hdl/chi_iota_step.sv
hdl/round_const_gen.sv
hdl/lane_store.sv
hdl/perm_ctrl.sv
hdl/keccak_perm_blk.sv
bench/perm_checker.sv
bench/tb_keccak_perm.sv
